// File: verilog/alu_exec_consts.svh
`ifndef ALU_EXEC_CONSTS_SVH
`define ALU_EXEC_CONSTS_SVH

// Datapath widths.
`define NB_DATA 32
`define NB_OP   6
`define NB_REG  5

// Word addresses on i_wb_adr[7:2].
`define ADR_REG_LAST 6'd31  // Registers occupy words 0 to 31.
`define ADR_INSTR    6'd32  // Byte 0x80.
`define ADR_RETIRED  6'd33  // Byte 0x84.

`endif

// File: verilog/alu_exec_pkg.sv
`include "alu_exec_consts.svh"

package alu_exec_pkg;

    // R-type funct codes and I-type opcodes share one space.
    typedef enum logic [`NB_OP-1:0] {
        ALU_SLL   = 6'b000000,
        ALU_SRL   = 6'b000010,
        ALU_SRA   = 6'b000011,
        ALU_SLLV  = 6'b000100,
        ALU_SRLV  = 6'b000110,
        ALU_SRAV  = 6'b000111,
        ALU_ADDI  = 6'b001000,
        ALU_ADDIU = 6'b001001,
        ALU_SLTI  = 6'b001010,
        ALU_SLTIU = 6'b001011,
        ALU_ANDI  = 6'b001100,
        ALU_ORI   = 6'b001101,
        ALU_XORI  = 6'b001110,
        ALU_LUI   = 6'b001111,
        ALU_ADD   = 6'b100000,
        ALU_ADDU  = 6'b100001,
        ALU_SUB   = 6'b100010,
        ALU_SUBU  = 6'b100011,
        ALU_AND   = 6'b100100,
        ALU_OR    = 6'b100101,
        ALU_XOR   = 6'b100110,
        ALU_NOR   = 6'b100111,
        ALU_SLT   = 6'b101010,
        ALU_SLTU  = 6'b101011,
        ALU_IDLE  = 6'b111111
    } alu_op_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DECODE,
        ST_EXEC,
        ST_ACK,
        ST_ERR
    } exec_state_t;

endpackage

// File: verilog/alu.sv
`timescale 1ns/1ps
`include "alu_exec_consts.svh"

module alu
    import alu_exec_pkg::*;
(
    input  logic [`NB_DATA-1:0] i_data_a,
    input  logic [`NB_DATA-1:0] i_data_b,
    input  alu_op_t             i_op,
    input  logic [4:0]          i_shamt,
    output logic [`NB_DATA-1:0] o_alu_result
);

    logic [4:0] var_shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign var_shamt   = i_data_a[4:0];  // Variable shifts take only the low bits of A.
    assign lt_signed   = $signed(i_data_a) < $signed(i_data_b);
    assign lt_unsigned = i_data_a < i_data_b;

    always_comb begin
        case (i_op)
            ALU_ADD, ALU_ADDU, ALU_ADDI, ALU_ADDIU: begin
                o_alu_result = i_data_a + i_data_b;  // No overflow trap.
            end
            ALU_SUB, ALU_SUBU: begin
                o_alu_result = i_data_a - i_data_b;
            end
            ALU_SLL: begin
                o_alu_result = i_data_b << i_shamt;
            end
            ALU_SRL: begin
                o_alu_result = i_data_b >> i_shamt;
            end
            ALU_SRA: begin
                o_alu_result = $signed(i_data_b) >>> i_shamt;
            end
            ALU_SLLV: begin
                o_alu_result = i_data_b << var_shamt;
            end
            ALU_SRLV: begin
                o_alu_result = i_data_b >> var_shamt;
            end
            ALU_SRAV: begin
                o_alu_result = $signed(i_data_b) >>> var_shamt;
            end
            ALU_AND, ALU_ANDI: begin
                o_alu_result = i_data_a & i_data_b;
            end
            ALU_OR, ALU_ORI: begin
                o_alu_result = i_data_a | i_data_b;
            end
            ALU_XOR, ALU_XORI: begin
                o_alu_result = i_data_a ^ i_data_b;
            end
            ALU_NOR: begin
                o_alu_result = ~(i_data_a | i_data_b);
            end
            ALU_SLT, ALU_SLTI: begin
                o_alu_result = {{(`NB_DATA-1){1'b0}}, lt_signed};
            end
            ALU_SLTU, ALU_SLTIU: begin
                o_alu_result = {{(`NB_DATA-1){1'b0}}, lt_unsigned};
            end
            ALU_LUI: begin
                o_alu_result = i_data_b << 16;
            end
            default: begin
                o_alu_result = '0;  // IDLE and unknown codes.
            end
        endcase
    end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`include "alu_exec_consts.svh"

module reg_file (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic [`NB_REG-1:0]  i_rd_addr_a,
    input  logic [`NB_REG-1:0]  i_rd_addr_b,
    input  logic [`NB_REG-1:0]  i_rd_addr_c,
    output logic [`NB_DATA-1:0] o_rd_data_a,
    output logic [`NB_DATA-1:0] o_rd_data_b,
    output logic [`NB_DATA-1:0] o_rd_data_c,
    input  logic                i_we,
    input  logic [`NB_REG-1:0]  i_wr_addr,
    input  logic [`NB_DATA-1:0] i_wr_data
);

    logic [`NB_DATA-1:0] regs [2**`NB_REG];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**`NB_REG; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_wr_addr != '0)) begin  // Register 0 stays zero.
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    assign o_rd_data_a = regs[i_rd_addr_a];
    assign o_rd_data_b = regs[i_rd_addr_b];
    assign o_rd_data_c = regs[i_rd_addr_c];  // Bus side.

    // Both write sources must settle the address before the edge.
    a_wr_addr_known: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_we |-> !$isunknown(i_wr_addr)
    ) else $error("register file write with unknown address");

endmodule

// File: verilog/instr_decode.sv
`timescale 1ns/1ps
`include "alu_exec_consts.svh"

module instr_decode
    import alu_exec_pkg::*;
(
    input  logic [`NB_DATA-1:0] i_instr,
    output alu_op_t             o_op,
    output logic [`NB_REG-1:0]  o_rs,
    output logic [`NB_REG-1:0]  o_rt,
    output logic [`NB_REG-1:0]  o_dest,
    output logic [4:0]          o_shamt,
    output logic [`NB_DATA-1:0] o_imm,
    output logic                o_use_imm,
    output logic                o_valid
);

    logic [`NB_OP-1:0] opcode;
    logic [`NB_OP-1:0] funct;
    logic              r_type;
    logic              r_ok;
    logic              i_ok;
    logic              sign_ext;

    assign opcode = i_instr[31:26];
    assign funct  = i_instr[5:0];
    assign r_type = (opcode == '0);

    always_comb begin
        r_ok     = 1'b0;
        i_ok     = 1'b0;
        sign_ext = 1'b0;
        case (alu_op_t'(funct))
            ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
            ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV,
            ALU_SRAV: r_ok = 1'b1;
            default: r_ok = 1'b0;  // IDLE lands here too.
        endcase
        case (alu_op_t'(opcode))
            ALU_ADDI, ALU_ADDIU, ALU_SLTI, ALU_SLTIU: begin
                i_ok     = 1'b1;
                sign_ext = 1'b1;
            end
            ALU_ANDI, ALU_ORI, ALU_XORI, ALU_LUI: i_ok = 1'b1;
            default: i_ok = 1'b0;
        endcase
    end

    assign o_op      = r_type ? alu_op_t'(funct) : alu_op_t'(opcode);
    assign o_rs      = i_instr[25:21];
    assign o_rt      = i_instr[20:16];
    assign o_dest    = r_type ? i_instr[15:11] : i_instr[20:16];
    assign o_shamt   = i_instr[10:6];
    assign o_imm     = sign_ext ? {{16{i_instr[15]}}, i_instr[15:0]} : {16'b0, i_instr[15:0]};
    assign o_use_imm = !r_type;
    assign o_valid   = r_type ? r_ok : i_ok;

endmodule

// File: verilog/exec_ctrl.sv
`timescale 1ns/1ps

module exec_ctrl
    import alu_exec_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_wb_cyc,
    input  logic i_wb_stb,
    input  logic i_wb_we,
    input  logic i_is_instr,
    input  logic i_valid,
    output logic o_instr_load,
    output logic o_exec_we,
    output logic o_bus_we,
    output logic o_retire,
    output logic o_wb_ack,
    output logic o_wb_err
);

    exec_state_t state;
    exec_state_t state_next;
    logic        armed;  // Stb has been low since the last ack or err.
    logic        start;

    assign start = (state == ST_IDLE) && i_wb_cyc && i_wb_stb && armed;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_next = (i_wb_we && i_is_instr) ? ST_DECODE : ST_ACK;
                end
            end
            ST_DECODE: state_next = ST_EXEC;
            ST_EXEC:   state_next = i_valid ? ST_ACK : ST_ERR;
            default:   state_next = ST_IDLE;  // ACK and ERR last one cycle.
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= ST_IDLE;
            armed <= 1'b1;
        end else begin
            state <= state_next;
            if (!i_wb_stb) begin
                armed <= 1'b1;
            end else if (start) begin
                armed <= 1'b0;
            end
        end
    end

    assign o_instr_load = start && i_wb_we && i_is_instr;
    assign o_bus_we     = start && i_wb_we && !i_is_instr;
    assign o_exec_we    = (state == ST_EXEC) && i_valid;  // Write-back.
    assign o_retire     = o_exec_we;
    assign o_wb_ack     = (state == ST_ACK);
    assign o_wb_err     = (state == ST_ERR);

    // A response belongs to an open bus cycle.
    a_resp_needs_cyc: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) (o_wb_ack || o_wb_err) |-> i_wb_cyc
    ) else $error("response without cyc in %s", state.name());

    // Holds only while the master keeps stb up for the whole transfer.
    a_resp_needs_stb: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !i_wb_stb |-> !(o_wb_ack || o_wb_err)
    ) else $error("response without stb in %s", state.name());

endmodule

// File: verilog/retire_counter.sv
`timescale 1ns/1ps
`include "alu_exec_consts.svh"

module retire_counter (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_retire,
    input  logic                i_clear,
    output logic [`NB_DATA-1:0] o_count
);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_count <= '0;
        end else if (i_clear) begin  // Clear wins over retire.
            o_count <= '0;
        end else if (i_retire) begin
            o_count <= o_count + 1'b1;
        end
    end

endmodule

// File: verilog/alu_exec_top.sv
`timescale 1ns/1ps
`include "alu_exec_consts.svh"

module alu_exec_top
    import alu_exec_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_wb_cyc,
    input  logic                i_wb_stb,
    input  logic                i_wb_we,
    input  logic [7:0]          i_wb_adr,
    input  logic [`NB_DATA-1:0] i_wb_dat,
    output logic [`NB_DATA-1:0] o_wb_dat,
    output logic                o_wb_ack,
    output logic                o_wb_err
);

    logic [5:0]          word_adr;
    logic                is_reg;
    logic                is_instr;
    logic                is_retired;
    logic [`NB_DATA-1:0] instr_q;
    alu_op_t             op;
    logic [`NB_REG-1:0]  rs;
    logic [`NB_REG-1:0]  rt;
    logic [`NB_REG-1:0]  dest;
    logic [4:0]          shamt;
    logic [`NB_DATA-1:0] imm;
    logic                use_imm;
    logic                valid;
    logic [`NB_DATA-1:0] rd_data_a;
    logic [`NB_DATA-1:0] rd_data_b;
    logic [`NB_DATA-1:0] rd_data_c;
    logic [`NB_DATA-1:0] operand_b;
    logic [`NB_DATA-1:0] alu_result;
    logic                instr_load;
    logic                exec_we;
    logic                bus_we;
    logic                retire;
    logic                rf_we;
    logic [`NB_REG-1:0]  rf_wr_addr;
    logic [`NB_DATA-1:0] rf_wr_data;
    logic [`NB_DATA-1:0] retired_count;

    assign word_adr   = i_wb_adr[7:2];
    assign is_reg     = (word_adr <= `ADR_REG_LAST);
    assign is_instr   = (word_adr == `ADR_INSTR);
    assign is_retired = (word_adr == `ADR_RETIRED);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            instr_q <= '0;
        end else if (instr_load) begin
            instr_q <= i_wb_dat;
        end
    end

    assign operand_b  = use_imm ? imm : rd_data_b;
    // Write-back has the port during execution, the bus otherwise.
    assign rf_we      = exec_we || (bus_we && is_reg);
    assign rf_wr_addr = exec_we ? dest : word_adr[`NB_REG-1:0];
    assign rf_wr_data = exec_we ? alu_result : i_wb_dat;

    always_comb begin
        if (is_reg) begin
            o_wb_dat = rd_data_c;
        end else if (is_instr) begin
            o_wb_dat = instr_q;
        end else if (is_retired) begin
            o_wb_dat = retired_count;
        end else begin
            o_wb_dat = '0;  // Unmapped words read as zero.
        end
    end

    instr_decode decode_i (
        .i_instr(instr_q), .o_op(op), .o_rs(rs), .o_rt(rt), .o_dest(dest),
        .o_shamt(shamt), .o_imm(imm), .o_use_imm(use_imm), .o_valid(valid)
    );

    reg_file reg_file_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_rd_addr_a(rs), .i_rd_addr_b(rt), .i_rd_addr_c(word_adr[`NB_REG-1:0]),
        .o_rd_data_a(rd_data_a), .o_rd_data_b(rd_data_b), .o_rd_data_c(rd_data_c),
        .i_we(rf_we), .i_wr_addr(rf_wr_addr), .i_wr_data(rf_wr_data)
    );

    alu alu_i (
        .i_data_a(rd_data_a), .i_data_b(operand_b), .i_op(op),
        .i_shamt(shamt), .o_alu_result(alu_result)
    );

    exec_ctrl ctrl_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
        .i_is_instr(is_instr), .i_valid(valid),
        .o_instr_load(instr_load), .o_exec_we(exec_we), .o_bus_we(bus_we),
        .o_retire(retire), .o_wb_ack(o_wb_ack), .o_wb_err(o_wb_err)
    );

    retire_counter counter_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_retire(retire),
        .i_clear(bus_we && is_retired), .o_count(retired_count)
    );

endmodule

// File: verification/alu_exec_tb.sv
`timescale 1ns/1ps
`include "alu_exec_consts.svh"

module alu_exec_tb
    import alu_exec_pkg::*;
();

    localparam int CLK_PERIOD = 8;

    logic                clk;
    logic                rst_n;
    logic                cyc;
    logic                stb;
    logic                we;
    logic [7:0]          adr;
    logic [`NB_DATA-1:0] dat_w;
    logic [`NB_DATA-1:0] dat_r;
    logic                ack;
    logic                err;
    logic [`NB_DATA-1:0] got;
    logic [`NB_DATA-1:0] lfsr_state = 32'd38;
    logic [`NB_DATA-1:0] shadow [32];  // Expected register contents.
    int                  retired = 0;
    int                  errors = 0;
    bit                  table_ready = 0;
    string               t_name [$];
    bit                  t_read [$];
    logic [7:0]          t_adr [$];
    logic [`NB_DATA-1:0] t_dat [$];
    logic [`NB_DATA-1:0] t_exp [$];  // Read data, or the err flag of a write.

    alu_exec_top dut_i (
        .i_clk(clk), .i_rst_n(rst_n), .i_wb_cyc(cyc), .i_wb_stb(stb), .i_wb_we(we),
        .i_wb_adr(adr), .i_wb_dat(dat_w), .o_wb_dat(dat_r), .o_wb_ack(ack), .o_wb_err(err)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Galois LFSR, one step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
        end
        return r;
    endfunction

    function automatic logic [31:0] model(input alu_op_t op, input logic [31:0] a,
                                          input logic [31:0] b, input logic [4:0] sh);
        logic [4:0] s;
        s = (op inside {ALU_SLLV, ALU_SRLV, ALU_SRAV}) ? a[4:0] : sh;
        case (op)
            ALU_ADD, ALU_ADDU, ALU_ADDI, ALU_ADDIU: return a + b;
            ALU_SUB, ALU_SUBU: return a - b;
            ALU_AND, ALU_ANDI: return a & b;
            ALU_OR, ALU_ORI: return a | b;
            ALU_XOR, ALU_XORI: return a ^ b;
            ALU_NOR: return ~(a | b);
            ALU_SLT, ALU_SLTI: return {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU, ALU_SLTIU: return {31'b0, a < b};
            ALU_SLL, ALU_SLLV: return b << s;
            ALU_SRL, ALU_SRLV: return b >> s;
            ALU_SRA, ALU_SRAV: return $signed(b) >>> s;
            ALU_LUI: return {b[15:0], 16'b0};
            default: return '0;
        endcase
    endfunction

    task automatic add(input string name, input bit rd, input logic [7:0] a,
                       input logic [31:0] d, input logic [31:0] e);
        t_name.push_back(name);
        t_read.push_back(rd);
        t_adr.push_back(a);
        t_dat.push_back(d);
        t_exp.push_back(e);
    endtask

    task automatic build_table();
        alu_op_t     r_ops [16] = '{ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_AND, ALU_OR,
                                    ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL,
                                    ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV};
        alu_op_t     i_ops [8] = '{ALU_ADDI, ALU_ADDIU, ALU_SLTI, ALU_SLTIU, ALU_ANDI,
                                   ALU_ORI, ALU_XORI, ALU_LUI};
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [15:0] imm;
        logic [31:0] ext;
        logic [31:0] instr;
        logic [31:0] v;
        add("reset_r5", 1, 8'h14, 0, 0);
        add("reset_count", 1, 8'h84, 0, 0);
        for (int r = 0; r < 10; r++) begin
            v = rand_bits(32);
            shadow[r] = (r == 0) ? '0 : v;  // Register 0 ignores writes.
            add($sformatf("wr_r%0d", r), 0, 8'(r * 4), v, 0);
            add($sformatf("rd_r%0d", r), 1, 8'(r * 4), 0, shadow[r]);
        end
        for (int i = 0; i < 16; i++) begin
            rs = 5'(1 + i % 9);
            rt = 5'(1 + (i + 4) % 9);
            rd = 5'(10 + i);
            sh = 5'(rand_bits(5));
            instr = {6'b0, rs, rt, rd, sh, r_ops[i]};
            v = model(r_ops[i], shadow[rs], shadow[rt], sh);
            add({"exec_", r_ops[i].name()}, 0, 8'h80, instr, 0);
            add({"rd_", r_ops[i].name()}, 1, 8'(rd * 4), 0, v);
            shadow[rd] = v;
            retired++;
        end
        for (int j = 0; j < 8; j++) begin
            rs = 5'(1 + j);
            rt = 5'(20 + j);
            imm = 16'(rand_bits(16));
            if (i_ops[j] inside {ALU_SLTI, ALU_SLTIU}) begin
                imm[15] = 1'b1;  // Negative immediate.
            end
            ext = (i_ops[j] inside {ALU_ADDI, ALU_ADDIU, ALU_SLTI, ALU_SLTIU}) ?
                  {{16{imm[15]}}, imm} : {16'b0, imm};
            instr = {i_ops[j], rs, rt, imm};
            v = model(i_ops[j], shadow[rs], ext, 5'd0);
            add({"exec_", i_ops[j].name()}, 0, 8'h80, instr, 0);
            add({"rd_", i_ops[j].name()}, 1, 8'(rt * 4), 0, v);
            shadow[rt] = v;
            retired++;
        end
        // Unsupported opcode and the IDLE funct end with err.
        add("bad_opcode", 0, 8'h80, {6'b000100, 5'd1, 5'd3, 16'h1234}, 1);
        add("bad_opcode_rt", 1, 8'h0c, 0, shadow[3]);
        instr = {6'b0, 5'd1, 5'd2, 5'd4, 5'd0, 6'b111111};
        add("bad_idle", 0, 8'h80, instr, 1);
        add("bad_idle_rd", 1, 8'h10, 0, shadow[4]);
        add("instr_readback", 1, 8'h80, 0, instr);
        add("retired_count", 1, 8'h84, 0, retired);
        add("count_clear", 0, 8'h84, 32'hffff_ffff, 0);
        add("count_after_clear", 1, 8'h84, 0, 0);
    endtask

    // One Wishbone classic transfer, held until ack or err.
    task automatic transfer(input logic write, input logic [7:0] a, input logic [31:0] d,
                            output logic [31:0] rdata, output logic got_err);
        @(negedge clk);
        cyc = 1'b1;
        stb = 1'b1;
        we = write;
        adr = a;
        dat_w = d;
        @(negedge clk);
        while (!(ack || err)) begin
            @(negedge clk);
        end
        rdata = dat_r;
        got_err = err;
        @(negedge clk);  // Response cycle ends on the posedge before this.
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
    endtask

    task automatic bus_write(input logic [7:0] a, input logic [31:0] d, output logic e);
        logic [31:0] unused;
        transfer(1'b1, a, d, unused, e);
    endtask

    task automatic bus_read(input logic [7:0] a, output logic [31:0] rdata, output logic e);
        transfer(1'b0, a, '0, rdata, e);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    initial begin
        wait (table_ready);
        #(t_name.size() * 20 * CLK_PERIOD);
        $display("Watchdog expired: the test table did not finish in time.");
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        logic e;
        rst_n = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int k = 0; k < t_name.size(); k++) begin
            if (t_read[k]) begin
                bus_read(t_adr[k], got, e);
                check({t_name[k], "_err"}, 32'd0, {31'b0, e});  // Reads always ack.
            end else begin
                bus_write(t_adr[k], t_dat[k], e);
                got = {31'b0, e};
            end
            check(t_name[k], t_exp[k], got);
        end
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: alu_exec_top.f
+incdir+verilog
verilog/alu_exec_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/instr_decode.sv
verilog/exec_ctrl.sv
verilog/retire_counter.sv
verilog/alu_exec_top.sv
verification/alu_exec_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f alu_exec_top.f --top-module alu_exec_tb -o alu_exec_sim

# The simulator exits non-zero on a failed check, so keep its output for the search.
out=$(./obj_dir/alu_exec_sim || true)
echo "$out"
if grep -q "ALL TESTS PASSED" <<< "$out"; then
    exit 0
fi
exit 1
